// ==== build.f ====
+incdir+test
design/uarch_pkg.sv
design/alu_decode.sv
design/alu.sv
design/alu_ctrl_regs.sv
design/alu_subsys_top.sv
test/alu_subsys_tb.sv

// ==== design/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 enable,
    input  logic                                 flush,
    input  logic                                 issue_valid,
    output logic                                 issue_ready,
    input  logic [2:0]                           alu_op,
    input  logic                                 is_sub_sra,
    input  logic [2:0]                           br_op,
    input  logic                                 is_branch,
    input  logic [uarch_pkg::reg_addr_bits-1:0]  dest,
    input  logic                                 illegal,
    input  logic [uarch_pkg::cpu_data_bits-1:0]  rs1_val,
    input  logic [uarch_pkg::cpu_data_bits-1:0]  rs2_val,
    output logic                                 cdb_valid,
    output logic [uarch_pkg::reg_addr_bits-1:0]  cdb_dest,
    output logic [uarch_pkg::cpu_data_bits-1:0]  cdb_value,
    output logic                                 cdb_is_branch,
    input  logic                                 cdb_gnt
);

    logic                                valid_q;
    logic                                accept;
    logic [2:0]                          alu_op_q;
    logic                                is_sub_sra_q;
    logic [2:0]                          br_op_q;
    logic                                is_branch_q;
    logic [uarch_pkg::reg_addr_bits-1:0] dest_q;
    logic [uarch_pkg::cpu_data_bits-1:0] rs1_q;
    logic [uarch_pkg::cpu_data_bits-1:0] rs2_q;
    logic [uarch_pkg::cpu_data_bits-1:0] op_result;
    logic [4:0]                          shamt;
    logic                                lt_s;
    logic                                lt_u;
    logic                                eq;
    logic                                br_taken;

    // a held result blocks issue until the bus takes it.
    assign issue_ready = enable && !flush && (!valid_q || cdb_gnt);
    assign accept      = issue_valid && issue_ready && !illegal;  // illegal words are dropped.

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (cdb_gnt) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op_q     <= alu_op;
            is_sub_sra_q <= is_sub_sra;
            br_op_q      <= br_op;
            is_branch_q  <= is_branch;
            dest_q       <= dest;
            rs1_q        <= rs1_val;
            rs2_q        <= rs2_val;
        end
    end

    // ********************
    // execute
    // ********************

    assign shamt = rs2_q[4:0];
    assign lt_s  = $signed(rs1_q) < $signed(rs2_q);
    assign lt_u  = rs1_q < rs2_q;
    assign eq    = rs1_q == rs2_q;

    always_comb begin
        case (alu_op_q)
            uarch_pkg::fnc_add_sub: op_result = is_sub_sra_q ? (rs1_q - rs2_q) : (rs1_q + rs2_q);
            uarch_pkg::fnc_sll:     op_result = rs1_q << shamt;
            uarch_pkg::fnc_slt:     op_result = {{(uarch_pkg::cpu_data_bits-1){1'b0}}, lt_s};
            uarch_pkg::fnc_sltu:    op_result = {{(uarch_pkg::cpu_data_bits-1){1'b0}}, lt_u};
            uarch_pkg::fnc_xor:     op_result = rs1_q ^ rs2_q;
            uarch_pkg::fnc_srl_sra: begin
                // sra copies the sign bit of rs1 into the vacated bits and srl fills them with zeros.
                if (is_sub_sra_q) begin
                    op_result = $signed(rs1_q) >>> shamt;
                end else begin
                    op_result = rs1_q >> shamt;
                end
            end
            uarch_pkg::fnc_or:      op_result = rs1_q | rs2_q;
            default:                op_result = rs1_q & rs2_q;
        endcase
    end

    always_comb begin
        case (br_op_q)
            uarch_pkg::fnc_beq:  br_taken = eq;
            uarch_pkg::fnc_bne:  br_taken = !eq;
            uarch_pkg::fnc_blt:  br_taken = lt_s;
            uarch_pkg::fnc_bge:  br_taken = !lt_s;
            uarch_pkg::fnc_bltu: br_taken = lt_u;
            uarch_pkg::fnc_bgeu: br_taken = !lt_u;
            default:             br_taken = 1'b0;
        endcase
    end

    assign cdb_valid     = valid_q;
    assign cdb_dest      = dest_q;
    assign cdb_is_branch = is_branch_q;
    assign cdb_value     = is_branch_q ? {{(uarch_pkg::cpu_data_bits-1){1'b0}}, br_taken}
                                       : op_result;

endmodule

// ==== design/alu_ctrl_regs.sv ====
`timescale 1ns/100ps

module alu_ctrl_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [11:0]                          paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [uarch_pkg::cpu_data_bits-1:0]  pwdata,
    output logic [uarch_pkg::cpu_data_bits-1:0]  prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  logic                                 issue_valid,
    input  logic                                 issue_ready,
    input  logic                                 illegal,
    input  logic                                 cdb_valid,
    input  logic                                 cdb_gnt,
    input  logic                                 cdb_is_branch,
    input  logic [uarch_pkg::cpu_data_bits-1:0]  cdb_value,
    output logic                                 enable,
    output logic                                 flush
);

    logic                               enable_q;
    logic [uarch_pkg::counter_bits-1:0] op_count_q;
    logic [uarch_pkg::counter_bits-1:0] taken_count_q;
    logic [uarch_pkg::counter_bits-1:0] illegal_count_q;
    logic                               apb_access;
    logic                               wr_ctrl;
    logic                               addr_hit;
    logic                               handshake;
    logic                               taken_event;
    logic                               illegal_event;

    // ********************
    // APB decode
    // ********************

    assign apb_access = psel && penable;  // the access phase is never stretched.
    assign wr_ctrl    = apb_access && pwrite && (paddr == uarch_pkg::reg_ctrl);
    assign pready     = 1'b1;
    assign pslverr    = apb_access && !addr_hit;

    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            uarch_pkg::reg_ctrl:          prdata = {{(uarch_pkg::cpu_data_bits-1){1'b0}}, enable_q};
            uarch_pkg::reg_op_count:      prdata = op_count_q;
            uarch_pkg::reg_taken_count:   prdata = taken_count_q;
            uarch_pkg::reg_illegal_count: prdata = illegal_count_q;
            default:                      addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b0;
        end else if (wr_ctrl) begin
            enable_q <= pwdata[0];
        end
    end

    assign enable = enable_q;
    assign flush  = wr_ctrl && pwdata[1];  // lasts only for the write's access phase.

    // ********************
    // event counters
    // ********************

    assign handshake     = cdb_valid && cdb_gnt;
    assign taken_event   = handshake && cdb_is_branch &&
                           (cdb_value == {{(uarch_pkg::cpu_data_bits-1){1'b0}}, 1'b1});
    assign illegal_event = issue_valid && issue_ready && illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_count_q      <= '0;
            taken_count_q   <= '0;
            illegal_count_q <= '0;
        end else begin
            if (handshake) begin
                op_count_q <= op_count_q + 1'b1;
            end
            if (taken_event) begin
                taken_count_q <= taken_count_q + 1'b1;
            end
            if (illegal_event) begin
                illegal_count_q <= illegal_count_q + 1'b1;
            end
        end
    end

endmodule

// ==== design/alu_decode.sv ====
`timescale 1ns/100ps

module alu_decode (
    input  uarch_pkg::instr_word_u                instr,
    output logic [2:0]                            alu_op,
    output logic                                  is_sub_sra,
    output logic [2:0]                            br_op,
    output logic                                  is_branch,
    output logic [uarch_pkg::reg_addr_bits-1:0]   dest,
    output logic                                  illegal
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] op_funct3;
    logic [2:0] br_funct3;

    assign opcode    = instr.r_view.opcode;
    assign funct7    = instr.r_view.funct7;
    assign op_funct3 = instr.r_view.funct3;
    assign br_funct3 = instr.b_view.funct3;  // only meaningful for a branch word.

    always_comb begin
        alu_op     = '0;
        is_sub_sra = 1'b0;
        br_op      = '0;
        is_branch  = 1'b0;
        dest       = '0;
        illegal    = 1'b0;

        if (opcode == uarch_pkg::opc_op) begin
            alu_op = op_funct3;
            dest   = instr.r_view.rd;
            if (funct7 == uarch_pkg::fnc7_sub_sra) begin
                is_sub_sra = 1'b1;
                // only add and srl have an alternate form.
                illegal = (op_funct3 != uarch_pkg::fnc_add_sub) &&
                          (op_funct3 != uarch_pkg::fnc_srl_sra);
            end else begin
                illegal = (funct7 != 7'b0000000);
            end
        end else if (opcode == uarch_pkg::opc_branch) begin
            is_branch = 1'b1;  // dest stays zero because a branch writes no register.
            br_op     = br_funct3;
            case (br_funct3)
                uarch_pkg::fnc_beq,
                uarch_pkg::fnc_bne,
                uarch_pkg::fnc_blt,
                uarch_pkg::fnc_bge,
                uarch_pkg::fnc_bltu,
                uarch_pkg::fnc_bgeu: begin
                    illegal = 1'b0;
                end
                default: begin
                    illegal = 1'b1;
                end
            endcase
        end else begin
            illegal = 1'b1;  // neither OP nor BRANCH.
        end
    end

endmodule

// ==== design/alu_subsys_top.sv ====
`timescale 1ns/100ps

module alu_subsys_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_valid,
    output logic                                 issue_ready,
    input  uarch_pkg::instr_word_u               issue_instr,
    input  logic [uarch_pkg::cpu_data_bits-1:0]  issue_rs1_val,
    input  logic [uarch_pkg::cpu_data_bits-1:0]  issue_rs2_val,
    output logic                                 cdb_valid,
    output logic [uarch_pkg::reg_addr_bits-1:0]  cdb_dest,
    output logic [uarch_pkg::cpu_data_bits-1:0]  cdb_value,
    output logic                                 cdb_is_branch,
    input  logic                                 cdb_gnt,
    input  logic [11:0]                          paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [uarch_pkg::cpu_data_bits-1:0]  pwdata,
    output logic [uarch_pkg::cpu_data_bits-1:0]  prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    logic [2:0]                          dec_alu_op;
    logic                                dec_is_sub_sra;
    logic [2:0]                          dec_br_op;
    logic                                dec_is_branch;
    logic [uarch_pkg::reg_addr_bits-1:0] dec_dest;
    logic                                dec_illegal;
    logic                                enable;
    logic                                flush;

    alu_decode alu_decode_i (
        .instr(issue_instr), .alu_op(dec_alu_op), .is_sub_sra(dec_is_sub_sra),
        .br_op(dec_br_op), .is_branch(dec_is_branch), .dest(dec_dest), .illegal(dec_illegal)
    );

    alu alu_i (
        .clk(clk), .rst(rst), .enable(enable), .flush(flush),
        .issue_valid(issue_valid), .issue_ready(issue_ready),
        .alu_op(dec_alu_op), .is_sub_sra(dec_is_sub_sra), .br_op(dec_br_op),
        .is_branch(dec_is_branch), .dest(dec_dest), .illegal(dec_illegal),
        .rs1_val(issue_rs1_val), .rs2_val(issue_rs2_val),
        .cdb_valid(cdb_valid), .cdb_dest(cdb_dest), .cdb_value(cdb_value),
        .cdb_is_branch(cdb_is_branch), .cdb_gnt(cdb_gnt)
    );

    // the register block watches the same handshakes the ALU sees.
    alu_ctrl_regs alu_ctrl_regs_i (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .illegal(dec_illegal), .cdb_valid(cdb_valid), .cdb_gnt(cdb_gnt),
        .cdb_is_branch(cdb_is_branch), .cdb_value(cdb_value),
        .enable(enable), .flush(flush)
    );

endmodule

// ==== design/uarch_pkg.sv ====
package uarch_pkg;

    // ********************
    // widths
    // ********************

    localparam int cpu_data_bits = 32;  // one machine word.
    localparam int reg_addr_bits = 5;
    localparam int counter_bits  = 32;

    // ********************
    // major opcodes
    // ********************

    localparam logic [6:0] opc_op     = 7'b0110011;  // register-register arithmetic.
    localparam logic [6:0] opc_branch = 7'b1100011;  // conditional branches.

    // funct3 codes of the OP group.
    localparam logic [2:0] fnc_add_sub = 3'b000;
    localparam logic [2:0] fnc_sll     = 3'b001;
    localparam logic [2:0] fnc_slt     = 3'b010;
    localparam logic [2:0] fnc_sltu    = 3'b011;
    localparam logic [2:0] fnc_xor     = 3'b100;
    localparam logic [2:0] fnc_srl_sra = 3'b101;
    localparam logic [2:0] fnc_or      = 3'b110;
    localparam logic [2:0] fnc_and     = 3'b111;

    // funct3 codes of the BRANCH group; 3'b010 and 3'b011 are unused.
    localparam logic [2:0] fnc_beq  = 3'b000;
    localparam logic [2:0] fnc_bne  = 3'b001;
    localparam logic [2:0] fnc_blt  = 3'b100;
    localparam logic [2:0] fnc_bge  = 3'b101;
    localparam logic [2:0] fnc_bltu = 3'b110;
    localparam logic [2:0] fnc_bgeu = 3'b111;

    localparam logic [6:0] fnc7_sub_sra = 7'b0100000;  // selects sub and sra.

    // ********************
    // instruction word
    // ********************

    // the same 32 bits seen as an R-type or a B-type word.
    typedef union packed {
        struct packed {
            logic [6:0]               funct7;
            logic [reg_addr_bits-1:0] rs2;
            logic [reg_addr_bits-1:0] rs1;
            logic [2:0]               funct3;
            logic [reg_addr_bits-1:0] rd;
            logic [6:0]               opcode;
        } r_view;
        struct packed {
            logic [6:0]               imm_hi;
            logic [reg_addr_bits-1:0] rs2;
            logic [reg_addr_bits-1:0] rs1;
            logic [2:0]               funct3;
            logic [4:0]               imm_lo;
            logic [6:0]               opcode;
        } b_view;
    } instr_word_u;

    // ********************
    // APB register map
    // ********************

    localparam logic [11:0] reg_ctrl          = 12'h000;  // bit 0 enable, bit 1 flush.
    localparam logic [11:0] reg_op_count      = 12'h004;
    localparam logic [11:0] reg_taken_count   = 12'h008;
    localparam logic [11:0] reg_illegal_count = 12'h00C;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the ALU subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

obj_dir=obj_dir
top=alu_subsys_tb

verilator --binary --timing -f build.f --top-module "$top" -Mdir "$obj_dir"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$("./$obj_dir/V$top")
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "test passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== test/alu_tb_checks.svh ====
`ifndef alu_tb_checks_svh
`define alu_tb_checks_svh

// ********************
// compare tasks
// ********************

task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_data(input logic [uarch_pkg::cpu_data_bits-1:0] got,
                          input logic [uarch_pkg::cpu_data_bits-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_dest(input logic [uarch_pkg::reg_addr_bits-1:0] got,
                          input logic [uarch_pkg::reg_addr_bits-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at time %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
endtask

task automatic check_count(input logic [uarch_pkg::counter_bits-1:0] got,
                           input logic [uarch_pkg::counter_bits-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

// ********************
// reference model
// ********************

function automatic logic [uarch_pkg::cpu_data_bits-1:0] ref_value(
    input logic is_br, input logic [2:0] f3, input logic [6:0] f7,
    input logic [uarch_pkg::cpu_data_bits-1:0] a, input logic [uarch_pkg::cpu_data_bits-1:0] b);
    logic [63:0] wide;
    logic [31:0] a_bias;
    logic [31:0] b_bias;
    logic [4:0]  sh;
    logic        alt;
    logic        hit;
    sh     = b[4:0];
    alt    = (f7 == uarch_pkg::fnc7_sub_sra);
    a_bias = a ^ 32'h8000_0000;  // flipping the sign bit makes a signed order unsigned.
    b_bias = b ^ 32'h8000_0000;
    wide   = {{32{alt & a[31]}}, a} >> sh;  // upper half is the fill for srl or sra.
    if (is_br) begin
        case (f3)
            uarch_pkg::fnc_beq:  hit = (a == b);
            uarch_pkg::fnc_bne:  hit = (a != b);
            uarch_pkg::fnc_blt:  hit = (a_bias < b_bias);
            uarch_pkg::fnc_bge:  hit = (a_bias >= b_bias);
            uarch_pkg::fnc_bltu: hit = (a < b);
            default:             hit = (a >= b);
        endcase
        return {31'd0, hit};
    end
    case (f3)
        uarch_pkg::fnc_add_sub: return alt ? (a + ~b + 32'd1) : (a + b);
        uarch_pkg::fnc_sll:     return a << sh;
        uarch_pkg::fnc_slt:     return {31'd0, a_bias < b_bias};
        uarch_pkg::fnc_sltu:    return {31'd0, a < b};
        uarch_pkg::fnc_xor:     return a ^ b;
        uarch_pkg::fnc_srl_sra: return wide[31:0];
        uarch_pkg::fnc_or:      return a | b;
        default:                return a & b;
    endcase
endfunction

// polls one ns after each falling edge, when the inputs have settled.
task automatic wait_issue_ready(input int limit);
    int n;
    n = 0;
    #1;
    while (!issue_ready && n < limit) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (!issue_ready) begin
        $display("timeout: issue_ready stayed low for %0d cycles", limit);
        abort_run();
    end
endtask

`endif

// ==== test/alu_subsys_tb.sv ====
`timescale 1ns/100ps

module alu_subsys_tb;

    localparam int wait_limit = 20;

    typedef struct packed {
        logic        is_br;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } stim_t;

    logic                                clk;
    logic                                rst;
    logic                                issue_valid;
    logic                                issue_ready;
    uarch_pkg::instr_word_u              issue_instr;
    logic [uarch_pkg::cpu_data_bits-1:0] issue_rs1_val;
    logic [uarch_pkg::cpu_data_bits-1:0] issue_rs2_val;
    logic                                cdb_valid;
    logic [uarch_pkg::reg_addr_bits-1:0] cdb_dest;
    logic [uarch_pkg::cpu_data_bits-1:0] cdb_value;
    logic                                cdb_is_branch;
    logic                                cdb_gnt;
    logic [11:0]                         paddr;
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    logic [uarch_pkg::cpu_data_bits-1:0] pwdata;
    logic [uarch_pkg::cpu_data_bits-1:0] prdata;
    logic                                pready;
    logic                                pslverr;

    int    seed = 32'h9fa70c71;
    int    checks = 0;
    int    errors = 0;
    int    tests = 0;
    int    granted = 0;  // results the bus has taken.
    int    taken = 0;
    stim_t stim_table[$];

    alu_subsys_top alu_subsys_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("test failed");
        $finish;
    endtask

    `include "alu_tb_checks.svh"

    // ********************
    // stimulus helpers
    // ********************

    function automatic stim_t stim_entry(input logic is_br, input logic [2:0] f3,
                                         input logic [6:0] f7, input logic [4:0] rd,
                                         input logic [31:0] a, input logic [31:0] b);
        stim_t e;
        e.is_br  = is_br;
        e.funct3 = f3;
        e.funct7 = f7;
        e.rd     = rd;
        e.rs1    = a;
        e.rs2    = b;
        return e;
    endfunction

    function automatic uarch_pkg::instr_word_u make_word(input stim_t e);
        uarch_pkg::instr_word_u w;
        if (e.is_br) begin
            w.b_view.imm_hi = e.funct7;
            w.b_view.rs2    = 5'd2;
            w.b_view.rs1    = 5'd1;
            w.b_view.funct3 = e.funct3;
            w.b_view.imm_lo = e.rd;  // sits where rd would be and must not reach cdb_dest.
            w.b_view.opcode = uarch_pkg::opc_branch;
        end else begin
            w.r_view.funct7 = e.funct7;
            w.r_view.rs2    = 5'd2;
            w.r_view.rs1    = 5'd1;
            w.r_view.funct3 = e.funct3;
            w.r_view.rd     = e.rd;
            w.r_view.opcode = uarch_pkg::opc_op;
        end
        return w;
    endfunction

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_add_sub, 7'h00, 5'd1,
                                        32'h7fff_ffff, 32'h0000_0001));
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_add_sub, uarch_pkg::fnc7_sub_sra,
                                        5'd2, 32'h0000_0000, 32'h0000_0001));
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_sll, 7'h00, 5'd3,
                                        32'h0000_0001, 32'hffff_ffff));
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_slt, 7'h00, 5'd4,
                                        32'hffff_ffff, 32'h0000_0001));
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_sltu, 7'h00, 5'd5,
                                        32'hffff_ffff, 32'h0000_0001));
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_srl_sra, uarch_pkg::fnc7_sub_sra,
                                        5'd6, 32'h8000_0000, 32'd31));
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_srl_sra, 7'h00, 5'd7,
                                        32'h8000_0000, 32'd31));
        stim_table.push_back(stim_entry(1'b1, uarch_pkg::fnc_beq, 7'h00, 5'd8,
                                        32'h1234_5678, 32'h1234_5678));
        stim_table.push_back(stim_entry(1'b1, uarch_pkg::fnc_bne, 7'h00, 5'd8,
                                        32'h1234_5678, 32'h1234_5678));
        stim_table.push_back(stim_entry(1'b1, uarch_pkg::fnc_blt, 7'h00, 5'd8,
                                        32'hffff_ffff, 32'h0000_0001));
        stim_table.push_back(stim_entry(1'b1, uarch_pkg::fnc_bltu, 7'h00, 5'd8,
                                        32'hffff_ffff, 32'h0000_0001));
        stim_table.push_back(stim_entry(1'b1, uarch_pkg::fnc_bge, 7'h00, 5'd8,
                                        32'h8000_0000, 32'h8000_0000));
        stim_table.push_back(stim_entry(1'b1, uarch_pkg::fnc_bgeu, 7'h00, 5'd8,
                                        32'h0000_0001, 32'hffff_ffff));
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            stim_table.push_back(stim_entry(1'b0, 3'(i), 7'h00, 5'(i + 10), a, b));
            if (3'(i) != 3'd2 && 3'(i) != 3'd3) begin
                stim_table.push_back(stim_entry(1'b1, 3'(i), 7'h00, 5'(i + 20), b, a));
            end
        end
        a = $random(seed);
        b = $random(seed);
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_add_sub, uarch_pkg::fnc7_sub_sra,
                                        5'd30, a, b));
        stim_table.push_back(stim_entry(1'b0, uarch_pkg::fnc_srl_sra, uarch_pkg::fnc7_sub_sra,
                                        5'd31, b, a));
        stim_table.push_back(stim_entry(1'b1, uarch_pkg::fnc_beq, 7'h00, 5'd9, a, a));
    endtask

    // ********************
    // bus drivers
    // ********************

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_count(data, exp, what);
        check_flag(err, 1'b0, {what, " pslverr"});
    endtask

    task automatic issue_word(input uarch_pkg::instr_word_u word,
                              input logic [31:0] a, input logic [31:0] b);
        issue_instr   = word;
        issue_rs1_val = a;
        issue_rs2_val = b;
        issue_valid   = 1'b1;
        wait_issue_ready(wait_limit);
        @(negedge clk);  // the word went in at the rising edge just passed.
        issue_valid = 1'b0;
    endtask

    // expects the grant high, so the result leaves one cycle after it shows up.
    task automatic run_entry(input stim_t e);
        logic [31:0] exp;
        exp = ref_value(e.is_br, e.funct3, e.funct7, e.rs1, e.rs2);
        issue_word(make_word(e), e.rs1, e.rs2);
        check_flag(cdb_valid, 1'b1, "cdb_valid one cycle after issue");
        check_flag(cdb_is_branch, e.is_br, "cdb_is_branch");
        check_dest(cdb_dest, e.is_br ? 5'd0 : e.rd, "cdb_dest");
        check_data(cdb_value, exp, "cdb_value");
        granted++;
        if (e.is_br && exp[0]) begin
            taken++;
        end
        @(negedge clk);
        check_flag(cdb_valid, 1'b0, "cdb_valid after grant");
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        $display("%-26s %s", name, (errors == mark) ? "ok" : "FAILED");
    endtask

    // ********************
    // test sequence
    // ********************

    initial begin
        int          mark;
        stim_t       a_ent;
        stim_t       b_ent;
        logic [31:0] rdata;
        logic        err;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_instr = '0;
        issue_rs1_val = '0;
        issue_rs2_val = '0;
        cdb_gnt = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        build_table();

        mark = errors;
        check_flag(issue_ready, 1'b0, "issue_ready after reset");
        check_flag(cdb_valid, 1'b0, "cdb_valid after reset");
        check_flag(pready, 1'b1, "pready");
        read_check(uarch_pkg::reg_op_count, 32'd0, "op_count after reset");
        read_check(uarch_pkg::reg_taken_count, 32'd0, "taken_count after reset");
        read_check(uarch_pkg::reg_illegal_count, 32'd0, "illegal_count after reset");
        apb_write(uarch_pkg::reg_ctrl, 32'h1);
        #1;
        check_flag(issue_ready, 1'b1, "issue_ready after enable");
        @(negedge clk);
        report_test("reset and enable", mark);

        mark = errors;
        cdb_gnt = 1'b1;
        foreach (stim_table[i]) begin
            if (!stim_table[i].is_br) begin
                run_entry(stim_table[i]);
            end
        end
        report_test("op results", mark);

        mark = errors;
        foreach (stim_table[i]) begin
            if (stim_table[i].is_br) begin
                run_entry(stim_table[i]);
            end
        end
        report_test("branch results", mark);

        mark = errors;
        a_ent = stim_entry(1'b0, uarch_pkg::fnc_xor, 7'h00, 5'd12, 32'hf0f0_f0f0, 32'h0ff0_0ff0);
        b_ent = stim_entry(1'b0, uarch_pkg::fnc_or, 7'h00, 5'd13, 32'h0000_00ff, 32'h1200_0000);
        cdb_gnt = 1'b0;
        issue_word(make_word(a_ent), a_ent.rs1, a_ent.rs2);
        issue_instr   = make_word(b_ent);  // b waits behind the held result of a.
        issue_rs1_val = b_ent.rs1;
        issue_rs2_val = b_ent.rs2;
        issue_valid   = 1'b1;
        repeat (4) begin
            #1;
            check_flag(cdb_valid, 1'b1, "held cdb_valid");
            check_flag(issue_ready, 1'b0, "issue_ready under back-pressure");
            check_data(cdb_value, ref_value(1'b0, a_ent.funct3, a_ent.funct7,
                                            a_ent.rs1, a_ent.rs2), "held cdb_value");
            check_dest(cdb_dest, a_ent.rd, "held cdb_dest");
            @(negedge clk);
        end
        cdb_gnt = 1'b1;
        granted++;
        wait_issue_ready(wait_limit);
        @(negedge clk);
        issue_valid = 1'b0;
        check_flag(cdb_valid, 1'b1, "cdb_valid for resumed word");
        check_dest(cdb_dest, b_ent.rd, "cdb_dest for resumed word");
        check_data(cdb_value, ref_value(1'b0, b_ent.funct3, b_ent.funct7,
                                        b_ent.rs1, b_ent.rs2), "cdb_value for resumed word");
        granted++;
        @(negedge clk);
        check_flag(cdb_valid, 1'b0, "cdb_valid after resumed word");
        report_test("back-pressure", mark);

        mark = errors;
        a_ent = stim_entry(1'b0, uarch_pkg::fnc_add_sub, 7'h00, 5'd14, 32'd5, 32'd6);
        issue_instr = make_word(a_ent);
        issue_instr.r_view.opcode = 7'b0000011;
        issue_word(issue_instr, 32'd5, 32'd6);
        check_flag(cdb_valid, 1'b0, "no result for unknown opcode");
        issue_word(make_word(stim_entry(1'b0, uarch_pkg::fnc_xor, 7'h01, 5'd15, 32'd1, 32'd2)),
                   32'd1, 32'd2);
        check_flag(cdb_valid, 1'b0, "no result for bad funct7");
        issue_word(make_word(stim_entry(1'b1, 3'b010, 7'h00, 5'd0, 32'd3, 32'd3)), 32'd3, 32'd3);
        check_flag(cdb_valid, 1'b0, "no result for branch funct3 2");
        read_check(uarch_pkg::reg_illegal_count, 32'd3, "illegal_count");
        cdb_gnt = 1'b0;
        issue_word(make_word(a_ent), a_ent.rs1, a_ent.rs2);
        check_flag(cdb_valid, 1'b1, "cdb_valid before flush");
        apb_write(uarch_pkg::reg_ctrl, 32'h3);  // keep enable, pulse flush.
        check_flag(cdb_valid, 1'b0, "cdb_valid after flush");
        read_check(uarch_pkg::reg_op_count, 32'(granted), "op_count after flush");
        cdb_gnt = 1'b1;
        report_test("illegal words and flush", mark);

        mark = errors;
        read_check(uarch_pkg::reg_op_count, 32'(granted), "final op_count");
        read_check(uarch_pkg::reg_taken_count, 32'(taken), "final taken_count");
        apb_read(12'h010, rdata, err);
        check_flag(err, 1'b1, "pslverr on unmapped address");
        report_test("final counters", mark);

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
